// ==== files.f ====
design/core_pkg.sv
design/fetch_if.sv
design/ifu.sv
design/idu.sv
design/gpr.sv
design/exu.sv
design/cpu_top.sv
sim/cpu_top_properties.sv
sim/tb_cpu_top.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_cpu_top -f files.f \
    -Mdir obj_dir -o tb_cpu_top

status=0
./obj_dir/tb_cpu_top > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "TB FAILED" sim.log || [ "$status" -ne 0 ]; then
    echo "simulation failed"
    exit 1
fi
echo "simulation finished without failures"

// ==== sim/tb_cpu_top.sv ====
// cpu_top testbench with clock, wishbone memory model, program and retire tables and checks
`timescale 1ns/1ps

module tb_cpu_top;

    localparam int          TIMEOUT_CYCLES = 60;
    localparam logic [15:0] LFSR_SEED      = 16'd22428;
    localparam logic [31:0] START_PC       = 32'h0000_0000;

    // rv32i major opcodes
    localparam logic [6:0] OP_REG   = 7'b0110011;
    localparam logic [6:0] OP_IMM   = 7'b0010011;
    localparam logic [6:0] OP_LUI   = 7'b0110111;
    localparam logic [6:0] OP_AUIPC = 7'b0010111;
    localparam logic [6:0] OP_JALR  = 7'b1100111;
    localparam logic [6:0] OP_LOAD  = 7'b0000011;  // not supported by the core

    logic        clk;
    logic        rst_i;
    logic        wb_cyc_o;
    logic        wb_stb_o;
    logic [31:0] wb_adr_o;
    logic [31:0] wb_dat_i;
    logic        wb_ack_i;
    logic        retire_valid_o;
    logic [31:0] retire_pc_o;
    logic [31:0] retire_next_pc_o;
    logic        retire_we_o;
    logic [4:0]  retire_rd_o;
    logic [31:0] retire_data_o;

    logic [31:0] prog [logic [29:0]];  // instruction words by word address
    logic [15:0] lfsr_q = LFSR_SEED;
    logic [31:0] cur_pc = START_PC;

    // expected retire rows in retirement order
    string       exp_name [$];
    logic [31:0] exp_pc [$];
    logic [31:0] exp_next [$];
    logic [31:0] exp_we [$];
    logic [31:0] exp_rd [$];
    logic [31:0] exp_data [$];

    cpu_top DUT (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);
    endfunction

    // two lfsr bits give 0..3 wait cycles
    task automatic draw_delay(output logic [1:0] d);
        for (int i = 0; i < 2; i++) begin
            d[i] = lfsr_q[0];
            lfsr_q = lfsr_next(lfsr_q);
        end
    endtask

    function automatic logic [31:0] enc_i(input logic [6:0] opc, input int f3, input int rd,
                                          input int rs1, input int imm);
        return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], opc};
    endfunction

    function automatic logic [31:0] enc_r(input int f3, input int f7, input int rd,
                                          input int rs1, input int rs2);
        return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], OP_REG};
    endfunction

    function automatic logic [31:0] enc_u(input logic [6:0] opc, input int rd, input int imm20);
        return {imm20[19:0], rd[4:0], opc};
    endfunction

    function automatic logic [31:0] enc_b(input int f3, input int rs1, input int rs2, input int off);
        return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3[2:0], off[4:1], off[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] enc_j(input int rd, input int off);
        return {off[20], off[10:1], off[11], off[19:12], rd[4:0], 7'b1101111};
    endfunction

    // unused words hold their own address and match no opcode
    function automatic logic [31:0] mem_word(input logic [31:0] addr);
        if (prog.exists(addr[31:2])) begin
            return prog[addr[31:2]];
        end else begin
            return addr;
        end
    endfunction

    // places one instruction at the running pc and records its retire row
    task automatic add_step(input string name, input logic [31:0] inst,
                            input logic [31:0] next_pc, input logic [31:0] we,
                            input logic [31:0] rd, input logic [31:0] data);
        prog[cur_pc[31:2]] = inst;
        exp_name.push_back(name);
        exp_pc.push_back(cur_pc);
        exp_next.push_back(next_pc);
        exp_we.push_back(we);
        exp_rd.push_back(rd);
        exp_data.push_back(data);
        cur_pc = next_pc;
    endtask

    task automatic stop_on_failure(input string msg);
        $display("%s", msg);
        $display("TB FAILED");
        $fatal(1, "simulation stopped at first failure");
    endtask

    task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            stop_on_failure($sformatf("error: %s expected %h actual %h", name, exp, act));
        end
    endtask

    // wishbone classic slave with a random ack delay per request
    initial begin : wb_slave
        logic [1:0] wait_left;
        logic       busy;
        wb_ack_i  = 1'b0;
        wb_dat_i  = '0;
        busy      = 1'b0;
        wait_left = '0;
        forever begin
            @(negedge clk);
            wb_ack_i = 1'b0;
            if (!rst_i && wb_cyc_o && wb_stb_o) begin
                if (!busy) begin
                    busy = 1'b1;
                    draw_delay(wait_left);
                end
                if (wait_left == 2'd0) begin
                    wb_ack_i = 1'b1;
                    wb_dat_i = mem_word(wb_adr_o);
                    busy     = 1'b0;
                end else begin
                    wait_left = wait_left - 2'd1;
                end
            end
        end
    end

    initial begin : main
        int waited;
        rst_i = 1'b1;
        add_step("addi_x1", enc_i(OP_IMM, 0, 1, 0, 100), 4, 1, 1, 100);
        add_step("addi_neg", enc_i(OP_IMM, 0, 2, 0, -7), 8, 1, 2, -7);
        add_step("lui", enc_u(OP_LUI, 3, 'h80000), 12, 1, 3, 'h80000 << 12);
        add_step("auipc", enc_u(OP_AUIPC, 4, 'h1), 16, 1, 4, 12 + ('h1 << 12));
        add_step("addi_x5", enc_i(OP_IMM, 0, 5, 0, 3), 20, 1, 5, 3);
        add_step("add", enc_r(0, 0, 6, 1, 2), 24, 1, 6, 100 + -7);
        add_step("sub", enc_r(0, 'h20, 7, 2, 1), 28, 1, 7, -7 - 100);
        add_step("and", enc_r(7, 0, 8, 1, 2), 32, 1, 8, 100 & -7);
        add_step("or", enc_r(6, 0, 9, 1, 2), 36, 1, 9, 100 | -7);
        add_step("xor", enc_r(4, 0, 10, 1, 2), 40, 1, 10, 100 ^ -7);
        add_step("slt", enc_r(2, 0, 11, 2, 1), 44, 1, 11, 1);   // -7 < 100 signed
        add_step("sltu", enc_r(3, 0, 12, 2, 1), 48, 1, 12, 0);  // 0xfffffff9 above 100
        add_step("sll", enc_r(1, 0, 13, 1, 5), 52, 1, 13, 100 << 3);
        add_step("srl", enc_r(5, 0, 14, 3, 5), 56, 1, 14, 32'h8000_0000 >> 3);
        add_step("sra", enc_r(5, 'h20, 15, 3, 5), 60, 1, 15, 32'hf000_0000);
        add_step("addi_x0", enc_i(OP_IMM, 0, 0, 1, 5), 64, 0, 0, 0);
        add_step("read_x0", enc_r(0, 0, 16, 1, 0), 68, 1, 16, 100);
        add_step("beq_taken", enc_b(0, 1, 1, 8), 76, 0, 0, 0);
        add_step("beq_not", enc_b(0, 1, 2, 8), 80, 0, 0, 0);
        add_step("bne_taken", enc_b(1, 1, 2, 8), 88, 0, 0, 0);
        add_step("bne_not", enc_b(1, 1, 1, 8), 92, 0, 0, 0);
        add_step("blt_taken", enc_b(4, 2, 1, 8), 100, 0, 0, 0);
        add_step("blt_not", enc_b(4, 1, 2, 8), 104, 0, 0, 0);
        add_step("bge_taken", enc_b(5, 1, 2, 8), 112, 0, 0, 0);
        add_step("bge_not", enc_b(5, 2, 1, 8), 116, 0, 0, 0);
        add_step("jal", enc_j(17, 12), 116 + 12, 1, 17, 116 + 4);
        add_step("jalr", enc_i(OP_JALR, 0, 18, 17, 21), (120 + 21) & ~1, 1, 18, 128 + 4);
        // lw x19, 4(x1), any write would leave x19 nonzero
        add_step("unsupported", enc_i(OP_LOAD, 2, 19, 1, 4), 144, 0, 0, 0);
        add_step("x19_unwritten", enc_r(0, 0, 20, 19, 1), 148, 1, 20, 100);

        repeat (3) @(negedge clk);
        rst_i = 1'b0;

        waited = 0;
        while (!wb_cyc_o) begin
            if (waited == TIMEOUT_CYCLES) begin
                stop_on_failure("no bus request after reset release");
            end
            @(negedge clk);
            waited++;
        end
        check_value("first_fetch adr", START_PC, wb_adr_o);

        for (int r = 0; r < exp_pc.size(); r++) begin
            waited = 0;
            @(negedge clk);
            while (!retire_valid_o) begin
                if (waited == TIMEOUT_CYCLES) begin
                    stop_on_failure({"timed out waiting for retire of ", exp_name[r]});
                end
                @(negedge clk);
                waited++;
            end
            check_value({exp_name[r], " pc"}, exp_pc[r], retire_pc_o);
            check_value({exp_name[r], " next_pc"}, exp_next[r], retire_next_pc_o);
            check_value({exp_name[r], " we"}, exp_we[r], {31'b0, retire_we_o});
            if (exp_we[r] != '0) begin
                check_value({exp_name[r], " rd"}, exp_rd[r], {27'b0, retire_rd_o});
                check_value({exp_name[r], " data"}, exp_data[r], retire_data_o);
            end
        end
        $display("TB PASSED");
        $finish;
    end

endmodule

// ==== sim/cpu_top_properties.sv ====
// concurrent assertions on the wishbone read port and the retire port of cpu_top
`timescale 1ns/1ps

module cpu_top_properties (
    input logic                                clk,
    input logic                                rst_i,
    input logic                                wb_cyc_i,
    input logic                                wb_stb_i,
    input logic [core_pkg::XLEN-1:0]           wb_adr_i,
    input logic                                wb_ack_i,
    input logic                                retire_valid_i,
    input logic                                retire_we_i,
    input logic [core_pkg::REG_ADDR_WIDTH-1:0] retire_rd_i
);

    stb_needs_cyc: assert property (@(posedge clk) disable iff (rst_i) wb_stb_i |-> wb_cyc_i)
        else $error("wb_stb_o high while wb_cyc_o is low");

    // request waiting on ack keeps strobe and address
    adr_held: assert property (@(posedge clk) disable iff (rst_i)
        (wb_stb_i && !wb_ack_i) |=> (wb_stb_i && $stable(wb_adr_i)))
        else $error("wishbone address or strobe changed before ack");

    retire_single: assert property (@(posedge clk) disable iff (rst_i)
        retire_valid_i |=> !retire_valid_i)
        else $error("retire_valid_o high two cycles running");

    no_x0_write: assert property (@(posedge clk) disable iff (rst_i)
        retire_we_i |-> (retire_rd_i != '0))
        else $error("retire reports a write to x0");

endmodule

bind cpu_top cpu_top_properties u_props (
    .clk            (clk),
    .rst_i          (rst_i),
    .wb_cyc_i       (wb_cyc_o),
    .wb_stb_i       (wb_stb_o),
    .wb_adr_i       (wb_adr_o),
    .wb_ack_i       (wb_ack_i),
    .retire_valid_i (retire_valid_o),
    .retire_we_i    (retire_we_o),
    .retire_rd_i    (retire_rd_o)
);

// ==== design/cpu_top.sv ====
// cpu top level: fetch, decode, register file and execute with plain bus and retire ports
`timescale 1ns/1ps

module cpu_top (
    input  logic                                clk,
    input  logic                                rst_i,
    // wishbone classic instruction port
    output logic                                wb_cyc_o,
    output logic                                wb_stb_o,
    output logic [core_pkg::XLEN-1:0]           wb_adr_o,
    input  logic [core_pkg::XLEN-1:0]           wb_dat_i,
    input  logic                                wb_ack_i,
    // retire port
    output logic                                retire_valid_o,
    output logic [core_pkg::XLEN-1:0]           retire_pc_o,
    output logic [core_pkg::XLEN-1:0]           retire_next_pc_o,
    output logic                                retire_we_o,
    output logic [core_pkg::REG_ADDR_WIDTH-1:0] retire_rd_o,
    output logic [core_pkg::XLEN-1:0]           retire_data_o
);
    import core_pkg::*;

    logic [REG_ADDR_WIDTH-1:0] rs1_addr;
    logic [REG_ADDR_WIDTH-1:0] rs2_addr;
    logic [XLEN-1:0]           rs1_data;
    logic [XLEN-1:0]           rs2_data;
    dec_info_t                 dec;
    logic                      rd_we;
    logic [REG_ADDR_WIDTH-1:0] rd_addr;
    logic [XLEN-1:0]           rd_data;

    fetch_if u_fetch_if ();

    ifu u_ifu (
        .clk      (clk),
        .rst_i    (rst_i),
        .wb_cyc_o (wb_cyc_o),
        .wb_stb_o (wb_stb_o),
        .wb_adr_o (wb_adr_o),
        .wb_dat_i (wb_dat_i),
        .wb_ack_i (wb_ack_i),
        .fif      (u_fetch_if.fetch)
    );

    idu u_idu (
        .fif        (u_fetch_if.decode),
        .rs1_addr_o (rs1_addr),
        .rs2_addr_o (rs2_addr),
        .dec_o      (dec)
    );

    gpr u_gpr (
        .clk        (clk),
        .rst_i      (rst_i),
        .rs1_addr_i (rs1_addr),
        .rs2_addr_i (rs2_addr),
        .we_i       (rd_we),
        .waddr_i    (rd_addr),
        .wdata_i    (rd_data),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data)
    );

    exu u_exu (
        .clk              (clk),
        .rst_i            (rst_i),
        .dec_i            (dec),
        .rs1_data_i       (rs1_data),
        .rs2_data_i       (rs2_data),
        .fif              (u_fetch_if.execute),
        .rd_we_o          (rd_we),
        .rd_addr_o        (rd_addr),
        .rd_data_o        (rd_data),
        .retire_valid_o   (retire_valid_o),
        .retire_pc_o      (retire_pc_o),
        .retire_next_pc_o (retire_next_pc_o),
        .retire_we_o      (retire_we_o),
        .retire_rd_o      (retire_rd_o),
        .retire_data_o    (retire_data_o)
    );

endmodule

// ==== design/exu.sv ====
// execute unit: alu, branch compare, next pc, register write and retire register
`timescale 1ns/1ps

module exu (
    input  logic                                clk,
    input  logic                                rst_i,
    input  core_pkg::dec_info_t                 dec_i,
    input  logic [core_pkg::XLEN-1:0]           rs1_data_i,
    input  logic [core_pkg::XLEN-1:0]           rs2_data_i,
    fetch_if.execute                            fif,
    // register file write port
    output logic                                rd_we_o,
    output logic [core_pkg::REG_ADDR_WIDTH-1:0] rd_addr_o,
    output logic [core_pkg::XLEN-1:0]           rd_data_o,
    // retire report, one cycle after execute
    output logic                                retire_valid_o,
    output logic [core_pkg::XLEN-1:0]           retire_pc_o,
    output logic [core_pkg::XLEN-1:0]           retire_next_pc_o,
    output logic                                retire_we_o,
    output logic [core_pkg::REG_ADDR_WIDTH-1:0] retire_rd_o,
    output logic [core_pkg::XLEN-1:0]           retire_data_o
);
    import core_pkg::*;

    logic [XLEN-1:0] op_a;
    logic [XLEN-1:0] op_b;
    logic [4:0]      shamt;
    logic [XLEN-1:0] alu_res;
    logic            eq;
    logic            lt;
    logic            taken;
    logic            link;
    logic [XLEN-1:0] seq_pc;
    logic [XLEN-1:0] target;
    logic [XLEN-1:0] wdata;

    assign op_a  = dec_i.use_pc ? fif.pc : rs1_data_i;
    assign op_b  = dec_i.use_imm ? dec_i.imm : rs2_data_i;
    assign shamt = op_b[4:0];

    always_comb begin
        case (dec_i.alu_op)
            ALU_ADD:    alu_res = op_a + op_b;
            ALU_SUB:    alu_res = op_a - op_b;
            ALU_AND:    alu_res = op_a & op_b;
            ALU_OR:     alu_res = op_a | op_b;
            ALU_XOR:    alu_res = op_a ^ op_b;
            ALU_SLT:    alu_res = {{(XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            ALU_SLTU:   alu_res = {{(XLEN-1){1'b0}}, op_a < op_b};
            ALU_SLL:    alu_res = op_a << shamt;
            ALU_SRL:    alu_res = op_a >> shamt;
            ALU_SRA:    alu_res = $unsigned($signed(op_a) >>> shamt);
            ALU_PASS_B: alu_res = op_b;
            default:    alu_res = op_a + op_b;
        endcase
    end

    // branch compare straight off the register operands
    assign eq = (rs1_data_i == rs2_data_i);
    assign lt = ($signed(rs1_data_i) < $signed(rs2_data_i));

    always_comb begin
        case (dec_i.br_op)
            BR_BEQ:  taken = eq;
            BR_BNE:  taken = !eq;
            BR_BLT:  taken = lt;
            BR_BGE:  taken = !lt;
            BR_JAL,
            BR_JALR: taken = 1'b1;
            default: taken = 1'b0;
        endcase
    end

    assign link   = (dec_i.br_op == BR_JAL) || (dec_i.br_op == BR_JALR);
    assign seq_pc = fif.pc + INST_STEP;
    // jalr target comes from the alu with bit 0 dropped
    assign target = (dec_i.br_op == BR_JALR) ? {alu_res[XLEN-1:1], 1'b0} : fif.pc + dec_i.imm;
    assign wdata  = link ? seq_pc : alu_res;

    assign fif.next_pc  = taken ? target : seq_pc;
    assign fif.redirect = taken;

    assign rd_we_o   = fif.inst_valid && dec_i.rd_we;
    assign rd_addr_o = dec_i.rd;
    assign rd_data_o = wdata;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            retire_valid_o <= 1'b0;
            retire_we_o    <= 1'b0;
        end else begin
            retire_valid_o <= fif.inst_valid;
            retire_we_o    <= rd_we_o;
        end
    end

    always_ff @(posedge clk) begin
        if (fif.inst_valid) begin
            retire_pc_o      <= fif.pc;
            retire_next_pc_o <= fif.next_pc;
            retire_rd_o      <= dec_i.rd;
            retire_data_o    <= wdata;
        end
    end

endmodule

// ==== design/gpr.sv ====
// general purpose register file: x1..x31, two async read ports, one write port
`timescale 1ns/1ps

module gpr (
    input  logic                                clk,
    input  logic                                rst_i,
    input  logic [core_pkg::REG_ADDR_WIDTH-1:0] rs1_addr_i,
    input  logic [core_pkg::REG_ADDR_WIDTH-1:0] rs2_addr_i,
    input  logic                                we_i,
    input  logic [core_pkg::REG_ADDR_WIDTH-1:0] waddr_i,
    input  logic [core_pkg::XLEN-1:0]           wdata_i,
    output logic [core_pkg::XLEN-1:0]           rs1_data_o,
    output logic [core_pkg::XLEN-1:0]           rs2_data_o
);
    import core_pkg::*;

    logic [XLEN-1:0] regs [1:(2**REG_ADDR_WIDTH)-1];  // no storage for x0

    always_ff @(posedge clk) begin
        if (rst_i) begin
            for (int i = 1; i < 2**REG_ADDR_WIDTH; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && waddr_i != '0) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    // x0 reads as zero
    assign rs1_data_o = (rs1_addr_i == '0) ? '0 : regs[rs1_addr_i];
    assign rs2_data_o = (rs2_addr_i == '0) ? '0 : regs[rs2_addr_i];

endmodule

// ==== design/idu.sv ====
// instruction decode unit: opcode classification, immediates, alu and branch op select
`timescale 1ns/1ps

module idu (
    fetch_if.decode                              fif,
    output logic [core_pkg::REG_ADDR_WIDTH-1:0] rs1_addr_o,
    output logic [core_pkg::REG_ADDR_WIDTH-1:0] rs2_addr_o,
    output core_pkg::dec_info_t                 dec_o
);
    import core_pkg::*;

    logic [XLEN-1:0] inst;
    opcode_e         opcode;
    logic [2:0]      funct3;
    logic [6:0]      funct7;
    logic [XLEN-1:0] imm_i;
    logic [XLEN-1:0] imm_u;
    logic [XLEN-1:0] imm_b;
    logic [XLEN-1:0] imm_j;
    dec_info_t       dec;

    // shared by OP and OP_IMM, alt picks sub/sra
    function automatic alu_op_e alu_decode(input logic [2:0] f3, input logic alt);
        alu_op_e op;
        case (f3)
            3'b000:  op = alt ? ALU_SUB : ALU_ADD;
            3'b001:  op = ALU_SLL;
            3'b010:  op = ALU_SLT;
            3'b011:  op = ALU_SLTU;
            3'b100:  op = ALU_XOR;
            3'b101:  op = alt ? ALU_SRA : ALU_SRL;
            3'b110:  op = ALU_OR;
            default: op = ALU_AND;
        endcase
        return op;
    endfunction

    assign inst   = fif.inst;
    assign opcode = opcode_e'(inst[6:0]);
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];

    assign imm_i = {{20{inst[31]}}, inst[31:20]};
    assign imm_u = {inst[31:12], 12'b0};
    assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

    always_comb begin
        dec        = '0;
        dec.alu_op = ALU_ADD;
        dec.br_op  = BR_NONE;
        dec.rd     = inst[11:7];
        case (opcode)
            OPC_OP: begin
                // only base funct7 values, M extension stays a no-op
                if (funct7 == 7'b0000000 || funct7 == 7'b0100000) begin
                    dec.alu_op = alu_decode(funct3, funct7[5]);
                    dec.rd_we  = 1'b1;
                end
            end
            OPC_OP_IMM: begin
                dec.alu_op  = alu_decode(funct3, funct3 == 3'b101 && funct7[5]);
                dec.use_imm = 1'b1;
                dec.imm     = imm_i;
                dec.rd_we   = 1'b1;
            end
            OPC_LUI: begin
                dec.alu_op  = ALU_PASS_B;
                dec.use_imm = 1'b1;
                dec.imm     = imm_u;
                dec.rd_we   = 1'b1;
            end
            OPC_AUIPC: begin
                dec.use_pc  = 1'b1;
                dec.use_imm = 1'b1;
                dec.imm     = imm_u;
                dec.rd_we   = 1'b1;
            end
            OPC_BRANCH: begin
                dec.imm = imm_b;
                case (funct3)
                    3'b000:  dec.br_op = BR_BEQ;
                    3'b001:  dec.br_op = BR_BNE;
                    3'b100:  dec.br_op = BR_BLT;
                    3'b101:  dec.br_op = BR_BGE;
                    default: dec.br_op = BR_NONE;  // unsigned forms unsupported
                endcase
            end
            OPC_JAL: begin
                dec.br_op = BR_JAL;
                dec.imm   = imm_j;
                dec.rd_we = 1'b1;
            end
            OPC_JALR: begin
                dec.br_op   = BR_JALR;
                dec.use_imm = 1'b1;  // alu forms rs1 + imm
                dec.imm     = imm_i;
                dec.rd_we   = 1'b1;
            end
            default: begin
                dec.rd_we = 1'b0;
            end
        endcase
        if (dec.rd == '0) begin
            dec.rd_we = 1'b0;  // x0 is never written
        end
    end

    assign rs1_addr_o = inst[19:15];
    assign rs2_addr_o = inst[24:20];
    assign dec_o      = dec;

endmodule

// ==== design/ifu.sv ====
// instruction fetch unit: pc, fetch sequencer and wishbone classic read master
`timescale 1ns/1ps

module ifu (
    input  logic                      clk,
    input  logic                      rst_i,
    // wishbone classic read master
    output logic                      wb_cyc_o,
    output logic                      wb_stb_o,
    output logic [core_pkg::XLEN-1:0] wb_adr_o,
    input  logic [core_pkg::XLEN-1:0] wb_dat_i,
    input  logic                      wb_ack_i,
    fetch_if.fetch                    fif
);
    import core_pkg::*;

    typedef enum logic [1:0] {
        S_ADV,   // advance to pc, open the first bus cycle
        S_REQ,   // bus cycle open, waiting on ack
        S_EXEC   // instruction handed to execute
    } fetch_state_e;

    fetch_state_e    state_q;
    logic [XLEN-1:0] pc_q;
    logic [XLEN-1:0] inst_q;

    // one instruction in flight, so this sequencer is the only stall point
    always_ff @(posedge clk) begin
        if (rst_i) begin
            state_q <= S_ADV;
            pc_q    <= RESET_PC;
        end else begin
            case (state_q)
                S_ADV: begin
                    state_q <= S_REQ;
                end
                S_REQ: begin
                    if (wb_ack_i) begin
                        state_q <= S_EXEC;
                    end
                end
                S_EXEC: begin
                    // step or follow the jump, next request opens right away
                    if (fif.redirect) begin
                        pc_q <= fif.next_pc;
                    end else begin
                        pc_q <= pc_q + INST_STEP;
                    end
                    state_q <= S_REQ;
                end
                default: begin
                    state_q <= S_ADV;
                end
            endcase
        end
    end

    // capture read data on the acknowledged cycle
    always_ff @(posedge clk) begin
        if (state_q == S_REQ && wb_ack_i) begin
            inst_q <= wb_dat_i;
        end
    end

    assign wb_cyc_o = (state_q == S_REQ);
    assign wb_stb_o = (state_q == S_REQ);
    assign wb_adr_o = pc_q;  // held until ack

    assign fif.inst_valid = (state_q == S_EXEC);  // one cycle per fetch
    assign fif.inst       = inst_q;
    assign fif.pc         = pc_q;

endmodule

// ==== design/fetch_if.sv ====
// fetch interface: fetched instruction, its pc, and the next pc from execute
`timescale 1ns/1ps

interface fetch_if;

    logic                      inst_valid;  // single-cycle execute slot
    logic [core_pkg::XLEN-1:0] inst;
    logic [core_pkg::XLEN-1:0] pc;
    logic [core_pkg::XLEN-1:0] next_pc;
    logic                      redirect;    // jump or taken branch

    modport fetch (
        output inst_valid, inst, pc,
        input  next_pc, redirect
    );

    modport decode (
        input inst
    );

    modport execute (
        input  inst_valid, pc,
        output next_pc, redirect
    );

endinterface

// ==== design/core_pkg.sv ====
// core package: widths, reset pc, opcode/alu/branch enums, decoded instruction struct
package core_pkg;

    localparam int XLEN           = 32;
    localparam int REG_ADDR_WIDTH = 5;

    localparam logic [XLEN-1:0] RESET_PC  = 32'h0000_0000;
    localparam logic [XLEN-1:0] INST_STEP = 32'd4;  // bytes per instruction

    // major opcodes the core executes, all others retire as no-ops
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111,
        OPC_BRANCH = 7'b1100011,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_SLTU,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_PASS_B  // lui
    } alu_op_e;

    typedef enum logic [2:0] {
        BR_NONE,
        BR_BEQ,
        BR_BNE,
        BR_BLT,
        BR_BGE,
        BR_JAL,
        BR_JALR
    } br_op_e;

    typedef struct packed {
        alu_op_e                   alu_op;
        br_op_e                    br_op;
        logic                      use_imm;  // operand b is imm
        logic                      use_pc;   // operand a is pc
        logic [XLEN-1:0]           imm;
        logic [REG_ADDR_WIDTH-1:0] rd;
        logic                      rd_we;
    } dec_info_t;

endpackage
